// File: verilog/rob_pkg.sv
// Sizes for the reorder buffer; N_ENTRIES and N_BANKS must be powers of two, N_BANKS < N_ENTRIES
package rob_pkg;

    // Ring of entries handed out to the client
    localparam int N_ENTRIES = 16;
    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Interleaved storage, low index bits pick the bank
    localparam int N_BANKS = 4;
    localparam int BANK_BITS = $clog2(N_BANKS);
    localparam int BANK_ROWS = N_ENTRIES / N_BANKS;

    // Payload widths
    localparam int DATA_BITS = 32;
    localparam int META_BITS = 4;

    // Slots held back before alloc permission drops
    localparam int MIN_FREE_SLOTS = 1;

    // Output queue, must be a power of two deep
    localparam int OUT_DEPTH = 4;
    localparam int OUT_THRESHOLD = 2;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [IDX_BITS-BANK_BITS-1:0] row_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [META_BITS-1:0] meta_t;

endpackage

// File: verilog/rob_if.sv
// Write side of the buffer; meta is written at alloc time, data later at any allocated index
interface rob_wr_if import rob_pkg::*; ();

    // Allocation, stores meta-data at the new index
    logic  meta_en;
    idx_t  meta_idx;
    meta_t meta;

    // Response write, any order
    logic  data_en;
    idx_t  data_idx;
    data_t data;

    // Top level fills everything from its ports
    modport source (
        output meta_en, meta_idx, meta,
        output data_en, data_idx, data
    );

    // Control only tracks arrival
    modport ctrl (
        input data_en, data_idx
    );

    // Banks store both halves of an entry
    modport bank (
        input meta_en, meta_idx, meta,
        input data_en, data_idx, data
    );

endinterface

// File: verilog/rob_ctrl.sv
// Single alloc per cycle; oldest_rdy lags a data write by at least two cycles
module rob_ctrl import rob_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    rob_wr_if.ctrl wr,
    input  logic   alloc,
    output logic   not_full,
    output idx_t   alloc_idx,
    input  logic   oldest_deq,
    output logic   oldest_rdy,
    output idx_t   oldest_idx
);

    // Ring pointers
    idx_t newest;
    idx_t oldest;

    // Occupancy with one extra bit so the compare never wraps
    idx_t occupied;
    logic [IDX_BITS:0] occ_ext;

    // Arrival tracking
    logic [N_ENTRIES-1:0] valid_next;
    logic [N_ENTRIES-1:0] valid_q;
    logic [1:0] valid_sub_q;
    logic oldest_deq_q;
    idx_t oldest_q;
    logic reset_q;

    assign alloc_idx = newest;
    assign oldest_idx = oldest;

    // Keep MIN_FREE_SLOTS entries unallocated
    assign occupied = newest - oldest;
    assign occ_ext = {1'b0, occupied} + (IDX_BITS + 1)'(MIN_FREE_SLOTS);
    assign not_full = occ_ext < (IDX_BITS + 1)'(N_ENTRIES);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            if (alloc)
                newest <= newest + 1'b1;
            if (oldest_deq)
                oldest <= oldest + 1'b1;
        end
    end

    // Next valid vector
    always_comb
    begin
        valid_next = valid_q;
        // Dequeued entry is cleared a cycle late
        if (oldest_deq_q)
            valid_next[oldest_q] = 1'b0;
        // A new arrival wins over the clear
        if (wr.data_en)
            valid_next[wr.data_idx] = 1'b1;
    end

    // Delayed local reset for the wide valid vector
    always_ff @(posedge clk)
    begin
        reset_q <= reset;
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            valid_q <= '0;
            valid_sub_q <= 2'b00;
            oldest_deq_q <= 1'b0;
        end
        else
        begin
            valid_q <= valid_next;
            oldest_deq_q <= oldest_deq;
            // Bit 0 for the current oldest, bit 1 for the one after it
            valid_sub_q <= {valid_q[idx_t'(oldest + 1'b1)], valid_q[oldest]};
        end
        oldest_q <= oldest;
    end

    // If the last cycle dequeued, the next entry is now oldest
    assign oldest_rdy = valid_sub_q[oldest_deq_q];

    // Client must respect not_full
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        alloc |-> (idx_t'(newest + 1'b1) != oldest));

    // Drain only takes entries that have arrived
    a_deq_ready: assert property (@(posedge clk) disable iff (reset)
        oldest_deq |-> oldest_rdy);

endmodule

// File: verilog/rob_bank.sv
// One interleaved bank; data must not be written in the cycle its entry is allocated
module rob_bank import rob_pkg::*; #(
    parameter int BANK_ID = 0
) (
    input  logic   clk,
    rob_wr_if.bank wr,
    input  row_t   read_row,
    output data_t  rd_data,
    output meta_t  rd_meta
);

    data_t data_mem [BANK_ROWS];
    meta_t meta_mem [BANK_ROWS];

    logic meta_hit;
    logic data_hit;
    row_t meta_row;
    row_t data_row;

    // Low index bits select the bank, upper bits the row
    assign meta_hit = wr.meta_en && (wr.meta_idx[BANK_BITS-1:0] == BANK_BITS'(BANK_ID));
    assign data_hit = wr.data_en && (wr.data_idx[BANK_BITS-1:0] == BANK_BITS'(BANK_ID));
    assign meta_row = wr.meta_idx[IDX_BITS-1:BANK_BITS];
    assign data_row = wr.data_idx[IDX_BITS-1:BANK_BITS];

    always_ff @(posedge clk)
    begin
        if (meta_hit)
            meta_mem[meta_row] <= wr.meta;
        if (data_hit)
            data_mem[data_row] <= wr.data;
    end

    // Registered read, one cycle after read_row
    always_ff @(posedge clk)
    begin
        rd_data <= data_mem[read_row];
        rd_meta <= meta_mem[read_row];
    end

    // Response may not land on the entry being allocated
    a_no_collide: assert property (@(posedge clk)
        !(meta_hit && data_hit && (meta_row == data_row)));

endmodule

// File: verilog/rob_drain.sv
// Drains ready entries into the output queue; word lands in the queue two cycles after oldest_deq
module rob_drain import rob_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  oldest_rdy,
    input  idx_t  oldest_idx,
    output logic  oldest_deq,
    output row_t  read_row,
    input  data_t bank_data [N_BANKS],
    input  meta_t bank_meta [N_BANKS],
    input  logic  deq_en,
    output logic  not_empty,
    output data_t first,
    output meta_t first_meta
);

    typedef logic [$clog2(OUT_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(OUT_DEPTH):0] cnt_t;

    // Read pipeline
    logic deq_q;
    logic deq_qq;
    logic [BANK_BITS-1:0] sel_q;
    data_t word_q;
    meta_t meta_q;

    // Output queue
    data_t q_data [OUT_DEPTH];
    meta_t q_meta [OUT_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push;

    // Threshold leaves room for the two words still in flight
    assign oldest_deq = oldest_rdy && (count < cnt_t'(OUT_THRESHOLD));
    assign read_row = oldest_idx[IDX_BITS-1:BANK_BITS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            deq_q <= 1'b0;
            deq_qq <= 1'b0;
        end
        else
        begin
            deq_q <= oldest_deq;
            deq_qq <= deq_q;
        end
        // Bank number follows the row read
        sel_q <= oldest_idx[BANK_BITS-1:0];
        // Bank output is valid now, pick the addressed one
        word_q <= bank_data[sel_q];
        meta_q <= bank_meta[sel_q];
    end

    assign push = deq_qq;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            q_data[wr_ptr] <= word_q;
            q_meta[wr_ptr] <= meta_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !deq_en)
                count <= count + 1'b1;
            else if (!push && deq_en)
                count <= count - 1'b1;
        end
    end

    // Head of the queue
    assign not_empty = (count != '0);
    assign first = q_data[rd_ptr];
    assign first_meta = q_meta[rd_ptr];

    // In-flight words always find a free slot
    a_no_q_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> ((count < cnt_t'(OUT_DEPTH)) || deq_en));

    // Consumer must wait for not_empty
    a_no_q_underflow: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty);

endmodule

// File: verilog/rob_top.sv
// Reorder buffer top; one alloc per cycle, writes always accepted, alloc only while not_full
module rob_top import rob_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  alloc,
    input  meta_t alloc_meta,
    output logic  not_full,
    output idx_t  alloc_idx,
    input  logic  wr_en,
    input  idx_t  wr_idx,
    input  data_t wr_data,
    input  logic  deq_en,
    output logic  not_empty,
    output data_t first,
    output meta_t first_meta
);

    rob_wr_if wr ();

    logic oldest_deq;
    logic oldest_rdy;
    idx_t oldest_idx;
    row_t read_row;
    data_t bank_data [N_BANKS];
    meta_t bank_meta [N_BANKS];

    // Ports onto the write interface
    assign wr.meta_en = alloc;
    assign wr.meta_idx = alloc_idx;
    assign wr.meta = alloc_meta;
    assign wr.data_en = wr_en;
    assign wr.data_idx = wr_idx;
    assign wr.data = wr_data;

    rob_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .alloc      (alloc),
        .not_full   (not_full),
        .alloc_idx  (alloc_idx),
        .oldest_deq (oldest_deq),
        .oldest_rdy (oldest_rdy),
        .oldest_idx (oldest_idx)
    );

    // Consecutive indices go to different banks
    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_bank
        rob_bank #(
            .BANK_ID (b)
        ) u_bank (
            .clk      (clk),
            .wr       (wr),
            .read_row (read_row),
            .rd_data  (bank_data[b]),
            .rd_meta  (bank_meta[b])
        );
    end

    rob_drain u_drain (
        .clk        (clk),
        .reset      (reset),
        .oldest_rdy (oldest_rdy),
        .oldest_idx (oldest_idx),
        .oldest_deq (oldest_deq),
        .read_row   (read_row),
        .bank_data  (bank_data),
        .bank_meta  (bank_meta),
        .deq_en     (deq_en),
        .not_empty  (not_empty),
        .first      (first),
        .first_meta (first_meta)
    );

endmodule

// File: test/clock_gen.sv
// Free-running testbench clock, starts low, first rising edge after half a period
module clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: test/rob_tb.sv
// Run from the project root so test/rob_patterns.txt is found; stops at the first error
module rob_tb import rob_pkg::*; ();

    localparam string PATTERN_FILE = "test/rob_patterns.txt";
    localparam int SEED = 30867;
    localparam int CYCLES_PER_OP = 40;
    localparam int WATCHDOG_MARGIN = 100;
    localparam int MAX_LINES = 64;
    localparam int RESET_CYCLES = 3;

    logic  clk;
    logic  reset;
    logic  alloc;
    meta_t alloc_meta;
    logic  not_full;
    idx_t  alloc_idx;
    logic  wr_en;
    idx_t  wr_idx;
    data_t wr_data;
    logic  deq_en;
    logic  not_empty;
    data_t first;
    meta_t first_meta;

    // Operation table, one row per pattern line
    string       op_name [MAX_LINES];
    byte         op_code [MAX_LINES];
    logic [31:0] op_a [MAX_LINES];
    logic [31:0] op_b [MAX_LINES];
    int          op_rep [MAX_LINES];
    int          n_ops;

    // Expected output stream, oldest first
    string exp_name [$];
    data_t exp_data [$];
    meta_t exp_meta [$];

    int   cycle_count;
    int   hold_end;
    int   budget;
    logic loaded;
    // Index the ring should hand out next
    idx_t next_idx;

    clock_gen #(.PERIOD(8)) u_clk (.clk(clk));

    rob_top UUT (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_meta (alloc_meta),
        .not_full   (not_full),
        .alloc_idx  (alloc_idx),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .deq_en     (deq_en),
        .not_empty  (not_empty),
        .first      (first),
        .first_meta (first_meta)
    );

    task automatic fail_and_stop(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_level(input string name, input string what, input logic expected,
                               input logic actual);
        assert (actual === expected)
        else
            fail_and_stop($sformatf("Mismatch in %s: %s expected %0b actual %0b",
                                    name, what, expected, actual));
    endtask

    // One clock, inputs change 1 unit after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic random_idle();
        int n;
        n = $urandom % 3;
        repeat (n)
            step();
    endtask

    task automatic load_patterns();
        int fd;
        int cnt;
        string line;
        string name;
        string code;
        logic [31:0] a;
        logic [31:0] b;
        int rep;
        fd = $fopen(PATTERN_FILE, "r");
        assert (fd != 0)
        else
            fail_and_stop("Could not open the pattern file");
        n_ops = 0;
        budget = 0;
        while ($fgets(line, fd) != 0)
        begin
            // Skip comments and blank lines
            if (line.len() == 0 || line[0] == "#")
                continue;
            cnt = $sscanf(line, "%s %s %h %h %h", name, code, a, b, rep);
            if (cnt <= 0)
                continue;
            assert (cnt == 5 && rep > 0)
            else
                fail_and_stop($sformatf("Pattern line is malformed: %s", line));
            assert (n_ops < MAX_LINES)
            else
                fail_and_stop("Pattern file has too many lines");
            op_name[n_ops] = name;
            op_code[n_ops] = code[0];
            op_a[n_ops] = a;
            op_b[n_ops] = b;
            op_rep[n_ops] = rep;
            budget += CYCLES_PER_OP * rep;
            // Holds and idles add their own length
            if (code[0] == "H" || code[0] == "I")
                budget += int'(a);
            // Expected words, data and meta step by one per repeat
            if (code[0] == "X")
            begin
                for (int k = 0; k < rep; k++)
                begin
                    exp_name.push_back(name);
                    exp_data.push_back(data_t'(a + k));
                    exp_meta.push_back(meta_t'(b + k));
                end
            end
            n_ops++;
        end
        $fclose(fd);
    endtask

    // Waits for room, checks the handed-out index against the ring count
    task automatic do_alloc(input string name, input meta_t meta);
        while (!not_full)
            step();
        assert (alloc_idx === next_idx)
        else
            fail_and_stop($sformatf("Mismatch in %s: alloc_idx expected %h actual %h",
                                    name, next_idx, alloc_idx));
        alloc = 1'b1;
        alloc_meta = meta;
        step();
        alloc = 1'b0;
        next_idx = next_idx + 1'b1;
    endtask

    task automatic do_write(input idx_t idx, input data_t data);
        wr_en = 1'b1;
        wr_idx = idx;
        wr_data = data;
        step();
        wr_en = 1'b0;
    endtask

    // Main sequence
    initial
    begin
        void'($urandom(SEED));
        reset = 1'b1;
        alloc = 1'b0;
        alloc_meta = '0;
        wr_en = 1'b0;
        wr_idx = '0;
        wr_data = '0;
        hold_end = 0;
        next_idx = '0;
        loaded = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge clk);
        #1;
        reset = 1'b0;
        step();
        check_level("reset", "not_empty", 1'b0, not_empty);
        check_level("reset", "not_full", 1'b1, not_full);
        for (int i = 0; i < n_ops; i++)
        begin
            // X lines only feed the drain side
            if (op_code[i] == "X")
                continue;
            for (int k = 0; k < op_rep[i]; k++)
            begin
                random_idle();
                case (op_code[i])
                    "A": do_alloc(op_name[i], meta_t'(op_a[i] + k));
                    "W": do_write(idx_t'(op_a[i] + k), data_t'(op_b[i] + k));
                    "H": hold_end = cycle_count + int'(op_a[i]);
                    "I": repeat (op_a[i]) step();
                    "F": check_level(op_name[i], "not_full", op_a[i][0], not_full);
                    default: fail_and_stop($sformatf("Unknown operation in line of %s",
                                                     op_name[i]));
                endcase
            end
        end
        // Everything expected must come out, and nothing after it
        while (exp_data.size() != 0)
            step();
        repeat (8)
            step();
        assert (!not_empty)
        else
            fail_and_stop("Output queue still holds a word after the last expected one");
        $display("Result: PASSED");
        $finish;
    end

    // Consumer, pops whenever a word waits and no hold is in force
    initial
    begin
        logic holding;
        logic kept;
        deq_en = 1'b0;
        cycle_count = 0;
        kept = 1'b0;
        forever
        begin
            @(posedge clk);
            holding = (cycle_count < hold_end);
            cycle_count = cycle_count + 1;
            #1;
            deq_en = 1'b0;
            // Queue cannot shrink without a dequeue
            if (kept)
                check_level(exp_name.size() != 0 ? exp_name[0] : "end", "not_empty",
                            1'b1, not_empty);
            if (not_empty && !holding)
            begin
                assert (exp_data.size() != 0)
                else
                    fail_and_stop($sformatf("Word %h came out after the last expected one",
                                            first));
                assert (first === exp_data[0])
                else
                    fail_and_stop($sformatf("Mismatch in %s: first expected %h actual %h",
                                            exp_name[0], exp_data[0], first));
                assert (first_meta === exp_meta[0])
                else
                    fail_and_stop($sformatf("Mismatch in %s: first_meta expected %h actual %h",
                                            exp_name[0], exp_meta[0], first_meta));
                void'(exp_name.pop_front());
                void'(exp_data.pop_front());
                void'(exp_meta.pop_front());
                deq_en = 1'b1;
            end
            kept = not_empty && !deq_en;
        end
    end

    // Watchdog sized from the pattern file
    initial
    begin
        wait (loaded === 1'b1);
        repeat (budget + WATCHDOG_MARGIN)
            @(posedge clk);
        fail_and_stop($sformatf("Timeout, run did not finish within %0d cycles",
                                budget + WATCHDOG_MARGIN));
    end

endmodule

// File: sources.f
verilog/rob_pkg.sv
verilog/rob_if.sv
verilog/rob_ctrl.sv
verilog/rob_bank.sv
verilog/rob_drain.sv
verilog/rob_top.sv
test/clock_gen.sv
test/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rob_tb -f sources.f -o rob_sim || exit 1
out=$(./obj_dir/rob_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Result: PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: test/rob_patterns.txt
# Columns: test op a b rep, numbers in hex; a line runs rep times, a and b step by one each time
# A alloc meta=a | W write idx=a data=b | H hold dequeue a cycles | I idle a cycles
# F expect not_full=a | X expected output data=a meta=b, in output order
full  A 0   0   f
full  F 0   0   1
full  W 8   108 7
full  W 0   100 4
full  W 4   104 4
full  I 14  0   1
full  F 1   0   1
full  X 100 0   f
order A 3   0   8
order W 4   205 3
order W 0   201 2
order W f   200 1
order W 2   203 2
order X 200 3   8
meta  A c   0   1
meta  A 5   0   1
meta  A 9   0   1
meta  W 9   3c9 1
meta  W 7   3c7 1
meta  W 8   3c8 1
meta  X 3c7 c   1
meta  X 3c8 5   1
meta  X 3c9 9   1
hold  H 40  0   1
hold  A 1   0   6
hold  W d   40d 3
hold  W a   40a 3
hold  X 40a 1   6
wrap  A 0   0   a
wrap  W 5   505 5
wrap  W 0   500 5
wrap  A a   0   a
wrap  W 0   510 4
wrap  W a   50a 6
wrap  X 500 0   14
